// File: sram_geom_pkg.sv
`default_nettype none

package sram_geom_pkg;

   // One SRAM macro
   localparam int DATA_SIZE  = 32;
   localparam int ADDR_SIZE  = 8;
   localparam int WMASK_SIZE = 4;
   localparam int NUM_WORDS  = 1 << ADDR_SIZE;

   // Each mask bit covers one byte of the word
   localparam int BYTE_SIZE = DATA_SIZE / WMASK_SIZE;

   // Chip select field, up to 16 macros
   localparam int SELECT_SIZE = 4;

   // One port group is addr, din, csb, web and wmask
   localparam int PORT_SIZE = ADDR_SIZE + DATA_SIZE + 2 + WMASK_SIZE;

   // Select followed by two port groups
   localparam int TOTAL_SIZE = SELECT_SIZE + 2 * PORT_SIZE;

endpackage

`default_nettype wire

// File: sram_cmd_pkg.sv
`default_nettype none

package sram_cmd_pkg;

   // Field group for one SRAM port, MSB first
   typedef struct packed {
      logic [sram_geom_pkg::ADDR_SIZE-1:0]  addr;
      logic [sram_geom_pkg::DATA_SIZE-1:0]  din;
      logic                                 csb;
      logic                                 web;
      logic [sram_geom_pkg::WMASK_SIZE-1:0] wmask;
   } port_fields_t;

   typedef struct packed {
      logic [sram_geom_pkg::SELECT_SIZE-1:0] select;
      port_fields_t                          port0;
      port_fields_t                          port1;
   } cmd_fields_t;

   // Raw view for shift and load, field view for decode and capture
   typedef union packed {
      logic [sram_geom_pkg::TOTAL_SIZE-1:0] raw;
      cmd_fields_t                          fields;
   } cmd_word_u;

   // Port with chip enable deasserted
   localparam port_fields_t PORT_IDLE = '{
      addr:  '0,
      din:   '0,
      csb:   1'b1,
      web:   1'b0,
      wmask: '0
   };

   // Reset value, no port active
   localparam cmd_word_u CMD_IDLE = cmd_word_u'(cmd_fields_t'{
      select: '0,
      port0:  PORT_IDLE,
      port1:  PORT_IDLE
   });

endpackage

`default_nettype wire

// File: cmd_scan_register.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_scan_register (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 scan_en,
   input  logic                                 scan_in,
   input  logic                                 load_en,
   input  logic [sram_geom_pkg::TOTAL_SIZE-1:0] load_data,
   input  logic                                 capture_en,
   input  logic [sram_geom_pkg::DATA_SIZE-1:0]  rd_data0,
   input  logic [sram_geom_pkg::DATA_SIZE-1:0]  rd_data1,
   output sram_cmd_pkg::cmd_word_u              cmd_word,
   output logic                                 scan_out
);

   sram_cmd_pkg::cmd_word_u cmd_next;

   // Strobe priority is scan, then load, then capture
   always_comb begin
      cmd_next = cmd_word;
      if (scan_en) begin
         // Shift toward the MSB, new bit enters at the LSB
         cmd_next.raw = {cmd_word.raw[sram_geom_pkg::TOTAL_SIZE-2:0], scan_in};
      end else if (load_en) begin
         cmd_next.raw = load_data;
      end else if (capture_en) begin
         // Only the data fields take the read words
         cmd_next.fields.port0.din = rd_data0;
         cmd_next.fields.port1.din = rd_data1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_word <= sram_cmd_pkg::CMD_IDLE;
      end else begin
         cmd_word <= cmd_next;
      end
   end

   // Serial output is the bit that leaves the chain next
   assign scan_out = cmd_word.raw[sram_geom_pkg::TOTAL_SIZE-1];

endmodule

`default_nettype wire

// File: port_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module port_decoder #(
   parameter int NUM_CHIPS = 16
) (
   input  sram_cmd_pkg::cmd_word_u                 cmd_word,
   output logic [sram_geom_pkg::SELECT_SIZE-1:0]   chip_sel,
   output logic [sram_geom_pkg::ADDR_SIZE-1:0]     addr0,
   output logic [sram_geom_pkg::DATA_SIZE-1:0]     din0,
   output logic                                    web0,
   output logic [sram_geom_pkg::WMASK_SIZE-1:0]    wmask0,
   output logic [NUM_CHIPS-1:0]                    csb0,
   output logic [sram_geom_pkg::ADDR_SIZE-1:0]     addr1,
   output logic [sram_geom_pkg::DATA_SIZE-1:0]     din1,
   output logic                                    web1,
   output logic [sram_geom_pkg::WMASK_SIZE-1:0]    wmask1,
   output logic [NUM_CHIPS-1:0]                    csb1
);

   assign chip_sel = cmd_word.fields.select;

   // Shared by every chip
   assign addr0  = cmd_word.fields.port0.addr;
   assign din0   = cmd_word.fields.port0.din;
   assign web0   = cmd_word.fields.port0.web;
   assign wmask0 = cmd_word.fields.port0.wmask;

   assign addr1  = cmd_word.fields.port1.addr;
   assign din1   = cmd_word.fields.port1.din;
   assign web1   = cmd_word.fields.port1.web;
   assign wmask1 = cmd_word.fields.port1.wmask;

   // One active-low enable per chip; out-of-range selects match nothing
   for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_csb
      localparam logic [sram_geom_pkg::SELECT_SIZE-1:0] CHIP_ID = i;

      assign csb0[i] = ~(~cmd_word.fields.port0.csb & (chip_sel == CHIP_ID));
      assign csb1[i] = ~(~cmd_word.fields.port1.csb & (chip_sel == CHIP_ID));
   end

endmodule

`default_nettype wire

// File: sram_macro_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_macro_model (
   input  logic                                 clk,
   input  logic                                 csb0,
   input  logic                                 web0,
   input  logic [sram_geom_pkg::WMASK_SIZE-1:0] wmask0,
   input  logic [sram_geom_pkg::ADDR_SIZE-1:0]  addr0,
   input  logic [sram_geom_pkg::DATA_SIZE-1:0]  din0,
   input  logic                                 csb1,
   input  logic                                 web1,
   input  logic [sram_geom_pkg::WMASK_SIZE-1:0] wmask1,
   input  logic [sram_geom_pkg::ADDR_SIZE-1:0]  addr1,
   input  logic [sram_geom_pkg::DATA_SIZE-1:0]  din1,
   output logic [sram_geom_pkg::DATA_SIZE-1:0]  dout0,
   output logic [sram_geom_pkg::DATA_SIZE-1:0]  dout1
);

   localparam int BW = sram_geom_pkg::BYTE_SIZE;

   logic [sram_geom_pkg::DATA_SIZE-1:0] mem [sram_geom_pkg::NUM_WORDS];

   // Both ports in one block since they share the storage.
   // Reads see the word as it was before this edge's writes
   always_ff @(posedge clk) begin
      if (!csb0) begin
         if (!web0) begin
            for (int b = 0; b < sram_geom_pkg::WMASK_SIZE; b++) begin
               if (wmask0[b]) begin
                  mem[addr0][b*BW +: BW] <= din0[b*BW +: BW];
               end
            end
         end else begin
            dout0 <= mem[addr0];
         end
      end

      if (!csb1) begin
         if (!web1) begin
            for (int b = 0; b < sram_geom_pkg::WMASK_SIZE; b++) begin
               if (wmask1[b]) begin
                  mem[addr1][b*BW +: BW] <= din1[b*BW +: BW];
               end
            end
         end else begin
            dout1 <= mem[addr1];
         end
      end
   end

endmodule

`default_nettype wire

// File: sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
   parameter int NUM_CHIPS = 16
) (
   input  logic                                  clk,
   input  logic [sram_geom_pkg::SELECT_SIZE-1:0] chip_sel,
   input  logic [sram_geom_pkg::ADDR_SIZE-1:0]   addr0,
   input  logic [sram_geom_pkg::DATA_SIZE-1:0]   din0,
   input  logic                                  web0,
   input  logic [sram_geom_pkg::WMASK_SIZE-1:0]  wmask0,
   input  logic [NUM_CHIPS-1:0]                  csb0,
   input  logic [sram_geom_pkg::ADDR_SIZE-1:0]   addr1,
   input  logic [sram_geom_pkg::DATA_SIZE-1:0]   din1,
   input  logic                                  web1,
   input  logic [sram_geom_pkg::WMASK_SIZE-1:0]  wmask1,
   input  logic [NUM_CHIPS-1:0]                  csb1,
   output logic [sram_geom_pkg::DATA_SIZE-1:0]   rd_data0,
   output logic [sram_geom_pkg::DATA_SIZE-1:0]   rd_data1
);

   logic [sram_geom_pkg::DATA_SIZE-1:0] dout0_all [NUM_CHIPS];
   logic [sram_geom_pkg::DATA_SIZE-1:0] dout1_all [NUM_CHIPS];

   for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_chip
      sram_macro_model u_macro (
         .clk    (clk),
         .csb0   (csb0[i]),
         .web0   (web0),
         .wmask0 (wmask0),
         .addr0  (addr0),
         .din0   (din0),
         .csb1   (csb1[i]),
         .web1   (web1),
         .wmask1 (wmask1),
         .addr1  (addr1),
         .din1   (din1),
         .dout0  (dout0_all[i]),
         .dout1  (dout1_all[i])
      );
   end

   // Read data of the selected chip, zeros past the last chip
   always_comb begin
      rd_data0 = '0;
      rd_data1 = '0;
      if (int'(chip_sel) < NUM_CHIPS) begin
         rd_data0 = dout0_all[chip_sel];
         rd_data1 = dout1_all[chip_sel];
      end
   end

endmodule

`default_nettype wire

// File: sram_testchip.sv
`timescale 1ns/1ps
`default_nettype none

module sram_testchip #(
   parameter int NUM_CHIPS = 16
) (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 scan_en,
   input  logic                                 scan_in,
   input  logic                                 load_en,
   input  logic [sram_geom_pkg::TOTAL_SIZE-1:0] load_data,
   input  logic                                 capture_en,
   output logic                                 scan_out,
   output logic [sram_geom_pkg::TOTAL_SIZE-1:0] cmd_data
);

   sram_cmd_pkg::cmd_word_u cmd_word;

   logic [sram_geom_pkg::SELECT_SIZE-1:0] chip_sel;
   logic [sram_geom_pkg::ADDR_SIZE-1:0]   addr0;
   logic [sram_geom_pkg::ADDR_SIZE-1:0]   addr1;
   logic [sram_geom_pkg::DATA_SIZE-1:0]   din0;
   logic [sram_geom_pkg::DATA_SIZE-1:0]   din1;
   logic                                  web0;
   logic                                  web1;
   logic [sram_geom_pkg::WMASK_SIZE-1:0]  wmask0;
   logic [sram_geom_pkg::WMASK_SIZE-1:0]  wmask1;
   logic [NUM_CHIPS-1:0]                  csb0;
   logic [NUM_CHIPS-1:0]                  csb1;
   logic [sram_geom_pkg::DATA_SIZE-1:0]   rd_data0;
   logic [sram_geom_pkg::DATA_SIZE-1:0]   rd_data1;

   cmd_scan_register u_cmd_reg (
      .clk        (clk),
      .reset      (reset),
      .scan_en    (scan_en),
      .scan_in    (scan_in),
      .load_en    (load_en),
      .load_data  (load_data),
      .capture_en (capture_en),
      .rd_data0   (rd_data0),
      .rd_data1   (rd_data1),
      .cmd_word   (cmd_word),
      .scan_out   (scan_out)
   );

   port_decoder #(
      .NUM_CHIPS (NUM_CHIPS)
   ) u_decoder (
      .cmd_word (cmd_word),
      .chip_sel (chip_sel),
      .addr0    (addr0),
      .din0     (din0),
      .web0     (web0),
      .wmask0   (wmask0),
      .csb0     (csb0),
      .addr1    (addr1),
      .din1     (din1),
      .web1     (web1),
      .wmask1   (wmask1),
      .csb1     (csb1)
   );

   sram_bank #(
      .NUM_CHIPS (NUM_CHIPS)
   ) u_bank (
      .clk      (clk),
      .chip_sel (chip_sel),
      .addr0    (addr0),
      .din0     (din0),
      .web0     (web0),
      .wmask0   (wmask0),
      .csb0     (csb0),
      .addr1    (addr1),
      .din1     (din1),
      .web1     (web1),
      .wmask1   (wmask1),
      .csb1     (csb1),
      .rd_data0 (rd_data0),
      .rd_data1 (rd_data1)
   );

   // Full register visible for parallel readback
   assign cmd_data = cmd_word.raw;

endmodule

`default_nettype wire

// File: sram_testchip_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sram_testchip_properties #(
   parameter int NUM_CHIPS = 16
) (
   input logic                                 clk,
   input logic                                 reset,
   input logic                                 scan_en,
   input logic [NUM_CHIPS-1:0]                 csb0,
   input logic [NUM_CHIPS-1:0]                 csb1,
   input logic                                 scan_out,
   input logic [sram_geom_pkg::TOTAL_SIZE-1:0] cmd_data
);

   // At most one chip enabled per port
   csb_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(~csb0) && $onehot0(~csb1))
      else $error("more than one chip enabled on a port");

   // Register holds the idle word right after reset
   idle_after_reset: assert property (@(posedge clk)
      ($past(reset) && !reset) |-> (&csb0 && &csb1))
      else $error("chip enabled in the cycle after reset");

   // A shift moves the bit below the MSB out to scan_out
   scan_out_shift: assert property (@(posedge clk) disable iff (reset)
      (!$past(reset) && $past(scan_en)) |->
         (scan_out == $past(cmd_data[sram_geom_pkg::TOTAL_SIZE-2])))
      else $error("scan_out is not the next bit of the shifted register");

endmodule

bind sram_testchip sram_testchip_properties #(
   .NUM_CHIPS (NUM_CHIPS)
) u_props (
   .clk      (clk),
   .reset    (reset),
   .scan_en  (scan_en),
   .csb0     (csb0),
   .csb1     (csb1),
   .scan_out (scan_out),
   .cmd_data (cmd_data)
);

`default_nettype wire

// File: sram_testchip_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sram_testchip_tb;

   localparam int NUM_CHIPS = 12;
   localparam int CMD_W     = sram_geom_pkg::TOTAL_SIZE;
   localparam int POLL_MAX  = 40;

   logic              clk = 1'b0;
   logic              reset;
   logic              scan_en;
   logic              scan_in;
   logic              load_en;
   logic [CMD_W-1:0]  load_data;
   logic              capture_en;
   logic              scan_out;
   logic [CMD_W-1:0]  cmd_data;

   // Expected storage of every chip
   logic [31:0] ref_mem [NUM_CHIPS][256];
   logic [31:0] lfsr_state = 32'hfd9d3811;

   // Request from the stimulus to the compare process
   logic             check_pending = 1'b0;
   logic             check_scan = 1'b0;
   logic [CMD_W-1:0] check_exp;
   int               errors = 0;
   int               checks = 0;
   int               test_err_start;

   sram_testchip #(
      .NUM_CHIPS (NUM_CHIPS)
   ) uut (
      .clk        (clk),
      .reset      (reset),
      .scan_en    (scan_en),
      .scan_in    (scan_in),
      .load_en    (load_en),
      .load_data  (load_data),
      .capture_en (capture_en),
      .scan_out   (scan_out),
      .cmd_data   (cmd_data)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic logic [7:0] rand_addr();
      logic [31:0] r;
      r = rand_bits(8);
      return r[7:0];
   endfunction

   function automatic logic [3:0] rand_chip();
      logic [31:0] r;
      r = rand_bits(8);
      return 4'(r % NUM_CHIPS);
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                               input logic [3:0] m);
      logic [31:0] w;
      w = old;
      for (int b = 0; b < 4; b++) begin
         if (m[b]) w[b*8 +: 8] = d[b*8 +: 8];
      end
      return w;
   endfunction

   function automatic sram_cmd_pkg::port_fields_t port_write(input logic [7:0] a,
                                                             input logic [31:0] d,
                                                             input logic [3:0] m);
      sram_cmd_pkg::port_fields_t p;
      p.addr  = a;
      p.din   = d;
      p.csb   = 1'b0;
      p.web   = 1'b0;
      p.wmask = m;
      return p;
   endfunction

   function automatic sram_cmd_pkg::port_fields_t port_read(input logic [7:0] a);
      sram_cmd_pkg::port_fields_t p;
      p.addr  = a;
      p.din   = '0;
      p.csb   = 1'b0;
      p.web   = 1'b1;
      p.wmask = '0;
      return p;
   endfunction

   function automatic sram_cmd_pkg::cmd_word_u make_cmd(input logic [3:0] sel,
      input sram_cmd_pkg::port_fields_t p0, input sram_cmd_pkg::port_fields_t p1);
      sram_cmd_pkg::cmd_word_u c;
      c.fields.select = sel;
      c.fields.port0  = p0;
      c.fields.port1  = p1;
      return c;
   endfunction

   // Applies one command to the reference storage, returns the word after capture
   function automatic sram_cmd_pkg::cmd_word_u ref_apply(input sram_cmd_pkg::cmd_word_u c);
      sram_cmd_pkg::cmd_word_u r;
      int sel;
      r = c;
      sel = int'(c.fields.select);
      if (sel >= NUM_CHIPS) begin
         r.fields.port0.din = '0;
         r.fields.port1.din = '0;
         return r;
      end
      // Reads see the old word
      if (!c.fields.port0.csb && c.fields.port0.web)
         r.fields.port0.din = ref_mem[sel][c.fields.port0.addr];
      if (!c.fields.port1.csb && c.fields.port1.web)
         r.fields.port1.din = ref_mem[sel][c.fields.port1.addr];
      if (!c.fields.port0.csb && !c.fields.port0.web)
         ref_mem[sel][c.fields.port0.addr] = merge_bytes(ref_mem[sel][c.fields.port0.addr],
            c.fields.port0.din, c.fields.port0.wmask);
      if (!c.fields.port1.csb && !c.fields.port1.web)
         ref_mem[sel][c.fields.port1.addr] = merge_bytes(ref_mem[sel][c.fields.port1.addr],
            c.fields.port1.din, c.fields.port1.wmask);
      return r;
   endfunction

   // Compare process, outputs are stable at the falling edge
   always @(negedge clk) begin
      logic [CMD_W-1:0] actual;
      if (check_pending) begin
         actual = check_scan ? {{(CMD_W-1){1'b0}}, scan_out} : cmd_data;
         checks++;
         assert (actual == check_exp) else begin
            $display("** Error at %0t: %s expected %h got %h", $time,
                     check_scan ? "scan_out" : "cmd_data", check_exp, actual);
            errors++;
         end
         check_pending = 1'b0;
      end
   end

   task automatic check_value(input logic [CMD_W-1:0] exp, input logic on_scan);
      int n;
      n = 0;
      check_exp = exp;
      check_scan = on_scan;
      check_pending = 1'b1;
      while (check_pending && n < POLL_MAX) begin
         #1;
         n++;
      end
      if (check_pending) begin
         $display("Timeout: the compare process did not take a check at %0t", $time);
         $display("Testbench failed");
         $finish;
      end
   endtask

   task automatic load_cmd(input logic [CMD_W-1:0] w);
      @(posedge clk);
      load_en   <= 1'b1;
      load_data <= w;
      @(posedge clk);
      load_en <= 1'b0;
   endtask

   task automatic write_cmd(input sram_cmd_pkg::cmd_word_u c);
      void'(ref_apply(c));
      load_cmd(c.raw);
   endtask

   // Capture lands two edges after the command is loaded
   task automatic read_and_check(input sram_cmd_pkg::cmd_word_u c);
      sram_cmd_pkg::cmd_word_u exp;
      exp = ref_apply(c);
      load_cmd(c.raw);
      @(posedge clk);
      capture_en <= 1'b1;
      @(posedge clk);
      capture_en <= 1'b0;
      check_value(exp.raw, 1'b0);
   endtask

   task automatic end_test(input string name);
      $display("Test %s done with %0d errors", name, errors - test_err_start);
      test_err_start = errors;
   endtask

   task automatic rw_through_ports(input logic swap);
      logic [3:0]  chip;
      logic [7:0]  a;
      logic [31:0] d_full;
      logic [31:0] d_mask;
      logic [31:0] r;
      sram_cmd_pkg::port_fields_t idle;
      idle = sram_cmd_pkg::PORT_IDLE;
      chip = rand_chip();
      a = rand_addr();
      d_full = rand_bits(32);
      d_mask = rand_bits(32);
      r = rand_bits(4);
      // Full write first so every byte is known, then the masked one
      if (!swap) begin
         write_cmd(make_cmd(chip, port_write(a, d_full, 4'hf), idle));
         write_cmd(make_cmd(chip, port_write(a, d_mask, r[3:0]), idle));
      end else begin
         write_cmd(make_cmd(chip, idle, port_write(a, d_full, 4'hf)));
         write_cmd(make_cmd(chip, idle, port_write(a, d_mask, r[3:0])));
      end
      write_cmd(sram_cmd_pkg::CMD_IDLE);
      read_and_check(make_cmd(chip, port_read(a), port_read(a)));
   endtask

   initial begin
      logic [CMD_W-1:0]        w;
      logic [3:0]              chip_a;
      logic [3:0]              chip_b;
      logic [7:0]              a;
      logic [7:0]              a2;
      logic [31:0]             r;
      sram_cmd_pkg::cmd_word_u c;

      reset = 1'b1;
      scan_en = 1'b0;
      scan_in = 1'b0;
      load_en = 1'b0;
      load_data = '0;
      capture_en = 1'b0;
      test_err_start = 0;

      repeat (10) @(posedge clk);
      reset <= 1'b0;
      check_value(sram_cmd_pkg::CMD_IDLE, 1'b0);
      end_test("reset value");

      w = {rand_bits(32), rand_bits(32), rand_bits(32)};
      load_cmd(w);
      repeat (3) @(posedge clk);
      check_value(w, 1'b0);
      end_test("parallel load");

      // MSB first so the word ends up in place
      w = {rand_bits(32), rand_bits(32), rand_bits(32)};
      for (int i = 0; i < CMD_W; i++) begin
         @(posedge clk);
         scan_en <= 1'b1;
         scan_in <= w[CMD_W-1-i];
      end
      @(posedge clk);
      scan_en <= 1'b0;
      check_value(w, 1'b0);
      check_value({{(CMD_W-1){1'b0}}, w[CMD_W-1]}, 1'b1);
      @(posedge clk);
      scan_en <= 1'b1;
      scan_in <= 1'b0;
      for (int k = 1; k < CMD_W; k++) begin
         @(posedge clk);
         check_value({{(CMD_W-1){1'b0}}, w[CMD_W-1-k]}, 1'b1);
      end
      @(posedge clk);
      scan_en <= 1'b0;
      end_test("scan in and out");

      rw_through_ports(1'b0);
      rw_through_ports(1'b1);
      end_test("masked write and read back");

      chip_a = rand_chip();
      chip_b = 4'((int'(chip_a) + 1 + int'(rand_bits(3))) % NUM_CHIPS);
      a = rand_addr();
      write_cmd(make_cmd(chip_a, port_write(a, rand_bits(32), 4'hf), sram_cmd_pkg::PORT_IDLE));
      write_cmd(make_cmd(chip_b, port_write(a, rand_bits(32), 4'hf), sram_cmd_pkg::PORT_IDLE));
      write_cmd(sram_cmd_pkg::CMD_IDLE);
      read_and_check(make_cmd(chip_a, port_read(a), port_read(a)));
      read_and_check(make_cmd(chip_b, port_read(a), port_read(a)));
      r = rand_bits(2);
      c = make_cmd(4'(12 + int'(r[1:0])), port_read(a), port_read(a));
      // Nonzero data fields so the captured zeros show
      c.fields.port0.din = rand_bits(32);
      c.fields.port1.din = rand_bits(32);
      read_and_check(c);
      end_test("chip isolation");

      chip_a = rand_chip();
      a = rand_addr();
      a2 = a ^ 8'h5a;
      write_cmd(make_cmd(chip_a, port_write(a, rand_bits(32), 4'hf),
                         port_write(a2, rand_bits(32), 4'hf)));
      write_cmd(sram_cmd_pkg::CMD_IDLE);
      read_and_check(make_cmd(chip_a, port_read(a), port_read(a2)));
      end_test("dual port read");

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sram_testchip.f
sram_geom_pkg.sv
sram_cmd_pkg.sv
cmd_scan_register.sv
port_decoder.sv
sram_macro_model.sv
sram_bank.sv
sram_testchip.sv
sram_testchip_properties.sv
sram_testchip_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module sram_testchip_tb -f sram_testchip.f -o sim_top

output=$(./obj_dir/sim_top)
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
   exit 0
else
   exit 1
fi
